//--- Bender.yml
package:
  name: rxdp_fifo

dependencies: {}

sources:
  # Package first, then the RTL bottom up
  - files:
      - rxdp_pkg.sv
      - rxdp_fifo_wr_ctl.sv
      - rxdp_fifo_ram.sv
      - rxdp_fifo_rd_ctl.sv
      - rxdp_fifo_top.sv

  # Testbench, top module tb_rxdp_fifo
  - target: test
    files:
      - tb_rxdp_fifo.sv

//--- rxdp_fifo_ram.sv
/* Register file of the receive FIFO, addressed by one-hot pointers. Read port two
   returns the entry after the read pointer for wide pops. */

`timescale 1ns/10ps

module rxdp_fifo_ram #(
   parameter int DEPTH                            // Number of entries, at least 2
) (
   input  logic                wr_clk,            // FIFO clock
   input  logic                wr_rst_n,          // Sync reset, active low
   input  logic                ram_we,            // Write strobe
   input  logic [DEPTH-1:0]    wr_ptr,            // One-hot write pointer
   input  rxdp_pkg::rx_word_t  wr_data,           // Word to store
   input  logic [DEPTH-1:0]    rd_ptr,            // One-hot read pointer
   output rxdp_pkg::rx_word_t  rd_data,           // Entry at rd_ptr
   output rxdp_pkg::rx_word_t  rd_data2           // Entry after rd_ptr
);

   rxdp_pkg::rx_word_t fifo_mem [DEPTH];          // Storage
   logic [DEPTH-1:0]   rd_ptr2;                   // Pointer one entry ahead

   //******************************
   // Write port
   //******************************

   // Cleared on reset so stale reads show zero
   always_ff @(posedge wr_clk) begin
      if (!wr_rst_n) begin
         for (int m = 0; m < DEPTH; m++) begin
            fifo_mem[m] <= '0;
         end
      end else if (ram_we) begin
         for (int m = 0; m < DEPTH; m++) begin
            if (wr_ptr[m]) begin
               fifo_mem[m] <= wr_data;              // Only the hot entry
            end
         end
      end
   end

   //******************************
   // Read ports
   //******************************

   // Next entry, wraps from the last back to entry 0
   assign rd_ptr2 = {rd_ptr[DEPTH-2:0], rd_ptr[DEPTH-1]};

   // One-hot select for both ports in one pass
   always_comb begin
      rd_data  = '0;
      rd_data2 = '0;
      for (int i = 0; i < DEPTH; i++) begin
         if (rd_ptr[i]) begin
            rd_data = fifo_mem[i];
         end
         if (rd_ptr2[i]) begin
            rd_data2 = fifo_mem[i];
         end
      end
   end

endmodule

//--- rxdp_fifo_rd_ctl.sv
/* Consumer side of the receive FIFO. Serves narrow or wide pops from the fill count,
   registers the output beat and moves the one-hot read pointer. */

`timescale 1ns/10ps

module rxdp_fifo_rd_ctl #(
   parameter int DEPTH                            // Number of entries, at least 2
) (
   input  logic                   wr_clk,         // FIFO clock
   input  logic                   wr_rst_n,       // Sync reset, active low
   input  logic                   rd_req,         // Read request pulse
   input  logic                   rd_wide,        // Ask for two words
   input  logic [$clog2(DEPTH):0] level,          // Registered occupancy
   input  logic                   evict,          // Oldest entry overwritten
   input  rxdp_pkg::rx_word_t     rd_data,        // Entry at rd_ptr
   input  rxdp_pkg::rx_word_t     rd_data2,       // Entry after rd_ptr
   output logic [DEPTH-1:0]       rd_ptr,         // One-hot read pointer
   output rxdp_pkg::rd_pop_s      pop,            // Entries removed now
   output rxdp_pkg::rx_out_s      out,            // Output beat
   output logic                   rd_underflow    // Request not served
);

   localparam int LVL_W = $clog2(DEPTH) + 1;

   logic               has_one;                   // At least one entry
   logic               has_two;                   // At least two entries
   logic               serve;                     // Request can be served
   logic [1:0]         step;                      // Pointer advance, 0 to 3
   logic [DEPTH-1:0]   rd_ptr_nxt;
   logic               out_valid;
   logic               out_wide;
   rxdp_pkg::rx_wide_t out_data;

   // Move a one-hot pointer on by one entry
   function automatic logic [DEPTH-1:0] rot1(input logic [DEPTH-1:0] p);
      return {p[DEPTH-2:0], p[DEPTH-1]};
   endfunction

   //******************************
   // Pop decision
   //******************************

   // Judged on the registered count, a write this cycle does not help
   assign has_one = (level != '0);
   assign has_two = (level >= LVL_W'(2));
   assign serve   = rd_req & (rd_wide ? has_two : has_one);

   assign pop = '{pop1: serve & ~rd_wide, pop2: serve & rd_wide};

   //******************************
   // Read pointer
   //******************************

   // Pop amount plus one slot skipped on eviction
   assign step = {pop.pop2, pop.pop1} + {1'b0, evict};

   always_comb begin
      rd_ptr_nxt = rd_ptr;
      for (int s = 0; s < 3; s++) begin
         if (s < step) begin
            rd_ptr_nxt = rot1(rd_ptr_nxt);
         end
      end
   end

   //******************************
   // Control registers
   //******************************

   always_ff @(posedge wr_clk) begin
      if (!wr_rst_n) begin
         rd_ptr       <= {{(DEPTH-1){1'b0}}, 1'b1};  // Entry 0
         out_valid    <= 1'b0;
         out_wide     <= 1'b0;
         rd_underflow <= 1'b0;
      end else begin
         rd_ptr       <= rd_ptr_nxt;
         out_valid    <= serve;                     // Beat one cycle after request
         out_wide     <= serve & rd_wide;
         rd_underflow <= rd_req & ~serve;           // Too few entries
      end
   end

   //******************************
   // Output data
   //******************************

   // Pre-edge buffer content, older word in the low half
   always_ff @(posedge wr_clk) begin
      if (serve) begin
         if (rd_wide) begin
            out_data <= {rd_data2, rd_data};
         end else begin
            out_data <= {{rxdp_pkg::rx_word_w{1'b0}}, rd_data};  // Upper half zero
         end
      end
   end

   assign out = '{valid: out_valid, wide: out_wide, data: out_data};

endmodule

//--- rxdp_fifo_top.sv
/* Receive datapath FIFO on a single clock. Wires the producer, the one-hot
   register file and the consumer together and sets their depth. */

`timescale 1ns/10ps

module rxdp_fifo_top #(
   parameter int DEPTH = rxdp_pkg::rxdp_depth_def  // Number of entries
) (
   input  logic               wr_clk,             // FIFO clock
   input  logic               wr_rst_n,           // Sync reset, active low
   input  logic               wr_en,              // Write strobe
   input  rxdp_pkg::rx_word_t wr_data,            // Receive word in
   input  logic               r_stop_write,       // Drop on full when set
   input  logic               rd_req,             // Read request pulse
   input  logic               rd_wide,            // Two words per request
   output rxdp_pkg::rx_out_s  out,                // Output beat
   output logic               wr_full,            // FIFO full
   output logic               rd_underflow,       // Request not served
   output logic               wr_overflow         // Word dropped or overwrote
);

   //******************************
   // Internal wiring
   //******************************

   logic                   ram_we;                // Buffer write strobe
   logic [DEPTH-1:0]       wr_ptr;                // One-hot write pointer
   logic [DEPTH-1:0]       rd_ptr;                // One-hot read pointer
   logic [$clog2(DEPTH):0] level;                 // Occupancy count
   logic                   evict;                 // Oldest entry replaced
   rxdp_pkg::rd_pop_s      pop;                   // Entries popped
   rxdp_pkg::rx_word_t     rd_data;
   rxdp_pkg::rx_word_t     rd_data2;

   // Producer
   rxdp_fifo_wr_ctl #(
      .DEPTH (DEPTH)
   ) wr_ctl_inst (
      .wr_clk       (wr_clk),
      .wr_rst_n     (wr_rst_n),
      .wr_en        (wr_en),
      .r_stop_write (r_stop_write),
      .pop          (pop),
      .ram_we       (ram_we),
      .wr_ptr       (wr_ptr),
      .level        (level),
      .wr_full      (wr_full),
      .evict        (evict),
      .wr_overflow  (wr_overflow)
   );

   // Storage
   rxdp_fifo_ram #(
      .DEPTH (DEPTH)
   ) ram_inst (
      .wr_clk   (wr_clk),
      .wr_rst_n (wr_rst_n),
      .ram_we   (ram_we),
      .wr_ptr   (wr_ptr),
      .wr_data  (wr_data),                        // Straight from the input
      .rd_ptr   (rd_ptr),
      .rd_data  (rd_data),
      .rd_data2 (rd_data2)
   );

   // Consumer
   rxdp_fifo_rd_ctl #(
      .DEPTH (DEPTH)
   ) rd_ctl_inst (
      .wr_clk       (wr_clk),
      .wr_rst_n     (wr_rst_n),
      .rd_req       (rd_req),
      .rd_wide      (rd_wide),
      .level        (level),
      .evict        (evict),
      .rd_data      (rd_data),
      .rd_data2     (rd_data2),
      .rd_ptr       (rd_ptr),
      .pop          (pop),
      .out          (out),
      .rd_underflow (rd_underflow)
   );

endmodule

//--- rxdp_fifo_wr_ctl.sv
/* Producer side of the receive FIFO. Owns the one-hot write pointer, the fill count,
   the full flag and the drop or overwrite policy when full. */

`timescale 1ns/10ps

module rxdp_fifo_wr_ctl #(
   parameter int DEPTH                            // Number of entries, at least 2
) (
   input  logic                   wr_clk,         // FIFO clock
   input  logic                   wr_rst_n,       // Sync reset, active low
   input  logic                   wr_en,          // Write strobe
   input  logic                   r_stop_write,   // Drop instead of overwrite when full
   input  rxdp_pkg::rd_pop_s      pop,            // Entries taken by the consumer
   output logic                   ram_we,         // Write strobe to the buffer
   output logic [DEPTH-1:0]       wr_ptr,         // One-hot write pointer
   output logic [$clog2(DEPTH):0] level,          // Occupancy count
   output logic                   wr_full,        // Count equals depth
   output logic                   evict,          // Oldest entry overwritten
   output logic                   wr_overflow     // Word dropped or overwrote
);

   localparam int LVL_W = $clog2(DEPTH) + 1;

   logic             accept;                      // Write into free space
   logic             overwrite;                   // Write on top of oldest
   logic             wr_blocked;                  // Write seen while full
   logic [LVL_W-1:0] pop_cnt;                     // 0, 1 or 2 entries removed
   logic [LVL_W-1:0] level_nxt;

   //******************************
   // Write policy
   //******************************

   // Full flag is the registered one, a pop in this cycle
   // only frees space from the next cycle on
   assign wr_blocked = wr_en & wr_full;
   assign accept     = wr_en & ~wr_full;
   assign overwrite  = wr_blocked & ~r_stop_write;  // Keep newest data

   // Buffer write lands at this edge, the word is readable next cycle
   assign ram_we = accept | overwrite;

   // Read side skips the overwritten slot at the same edge
   assign evict = overwrite;

   //******************************
   // Fill count
   //******************************

   assign pop_cnt = LVL_W'({pop.pop2, pop.pop1});   // pop2 weighs two

   // Overwrite leaves the count as it is
   assign level_nxt = level + LVL_W'(accept) - pop_cnt;

   //******************************
   // State
   //******************************

   always_ff @(posedge wr_clk) begin
      if (!wr_rst_n) begin
         wr_ptr      <= {{(DEPTH-1){1'b0}}, 1'b1};  // Entry 0
         level       <= '0;                         // Empty
         wr_full     <= 1'b0;
         wr_overflow <= 1'b0;
      end else begin
         if (ram_we) begin
            wr_ptr <= {wr_ptr[DEPTH-2:0], wr_ptr[DEPTH-1]};  // Rotate by one
         end
         level       <= level_nxt;
         wr_full     <= (level_nxt == LVL_W'(DEPTH));
         wr_overflow <= wr_blocked;                 // Drop or overwrite alike
      end
   end

endmodule

//--- rxdp_pkg.sv
/* Shared types for the receive datapath FIFO. Every RTL file and the testbench
   refer to these by scoped name. */

package rxdp_pkg;

   //******************************
   // Data widths
   //******************************

   localparam int rx_word_w = 40;                   // One receive word
   localparam int rx_wide_w = 2 * rx_word_w;        // Two words side by side

   // Single receive word as written by the producer
   typedef logic [rx_word_w-1:0] rx_word_t;

   // Pair of words, older entry in the low half
   typedef logic [rx_wide_w-1:0] rx_wide_t;

   //******************************
   // Sizing
   //******************************

   // Default number of entries, top level only
   localparam int rxdp_depth_def = 16;

   //******************************
   // Consumer to producer
   //******************************

   // Entries removed by the consumer in the current cycle.
   // At most one of the two bits is set.
   typedef struct packed {
      logic pop1;                                   // One entry popped
      logic pop2;                                   // Two entries popped
   } rd_pop_s;

   //******************************
   // Output beat
   //******************************

   // Registered output word, one beat per served request.
   // No back-pressure, a beat must be taken when valid is high.
   typedef struct packed {
      logic     valid;                              // Single cycle pulse
      logic     wide;                               // Beat holds two words
      rx_wide_t data;                               // High half zero if narrow
   } rx_out_s;

endpackage

//--- tb.f
rxdp_pkg.sv
rxdp_fifo_wr_ctl.sv
rxdp_fifo_ram.sv
rxdp_fifo_rd_ctl.sv
rxdp_fifo_top.sv
tb_rxdp_fifo.sv

//--- tb_rxdp_fifo.sv
/* Self-checking testbench for the receive FIFO top level. A queue model predicts every
   output one edge after the request and immediate assertions compare the DUT with it. */

`timescale 1ns/10ps

module tb_rxdp_fifo;

   localparam int DEPTH = 16;                     // Entries in the DUT

   logic               wr_clk;
   logic               wr_rst_n;
   logic               wr_en;
   rxdp_pkg::rx_word_t wr_data;
   logic               r_stop_write;
   logic               rd_req;
   logic               rd_wide;
   rxdp_pkg::rx_out_s  out;
   logic               wr_full;
   logic               rd_underflow;
   logic               wr_overflow;

   logic [31:0]        lfsr;                      // Random source state
   rxdp_pkg::rx_word_t model_q [$];               // Reference FIFO contents
   logic               exp_valid;                 // Predicted outputs
   logic               exp_wide;
   rxdp_pkg::rx_wide_t exp_data;
   logic               exp_full;
   logic               exp_ovf;
   logic               exp_unf;
   int                 wr_thr;                    // Write odds in eighths

   rxdp_fifo_top #(
      .DEPTH (DEPTH)
   ) rxdp_fifo_top_inst (
      .wr_clk       (wr_clk),
      .wr_rst_n     (wr_rst_n),
      .wr_en        (wr_en),
      .wr_data      (wr_data),
      .r_stop_write (r_stop_write),
      .rd_req       (rd_req),
      .rd_wide      (rd_wide),
      .out          (out),
      .wr_full      (wr_full),
      .rd_underflow (rd_underflow),
      .wr_overflow  (wr_overflow)
   );

   always #50 wr_clk = ~wr_clk;                   // 100 ns period

   //******************************
   // Random numbers
   //******************************

   // Right-shifting Galois LFSR with taps 32 30 26 25
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'ha3000000) : (s >> 1);
   endfunction

   // One LFSR step per bit taken
   function automatic logic [39:0] rand_bits(input int n);
      logic [39:0] v;
      v = '0;
      for (int b = 0; b < n; b++) begin
         lfsr = lfsr_step(lfsr);
         v    = {v[38:0], lfsr[0]};
      end
      return v;
   endfunction

   //******************************
   // Failure reporting
   //******************************

   task automatic report_mismatch(input string sig, input logic [79:0] got,
                                  input logic [79:0] exp);
      $display("** Error: %s is %h, expected %h", sig, got, exp);
      $display("TEST FAIL");
      $fatal(1);
   endtask

   //******************************
   // Reference model
   //******************************

   // One edge applied to the queue on the pre-edge count
   task automatic model_edge();
      int                 cnt;
      logic               full;
      rxdp_pkg::rx_word_t lo;
      rxdp_pkg::rx_word_t hi;
      cnt       = model_q.size();
      full      = (cnt == DEPTH);
      exp_valid = 1'b0;
      exp_wide  = 1'b0;
      exp_ovf   = 1'b0;
      exp_unf   = 1'b0;
      if (rd_req) begin
         if (cnt >= (rd_wide ? 2 : 1)) begin
            exp_valid = 1'b1;
            exp_wide  = rd_wide;
            lo        = model_q.pop_front();      // Oldest word
            if (rd_wide) begin
               hi       = model_q.pop_front();
               exp_data = {hi, lo};
            end else begin
               exp_data = {40'h0, lo};            // Upper half zero
            end
         end else begin
            exp_unf = 1'b1;                       // Too few entries
         end
      end
      if (wr_en) begin
         if (!full) begin
            model_q.push_back(wr_data);
         end else begin
            exp_ovf = 1'b1;
            if (!r_stop_write) begin
               void'(model_q.pop_front());        // Oldest survivor evicted
               model_q.push_back(wr_data);
            end
         end
      end
      exp_full = (model_q.size() == DEPTH);
   endtask

   //******************************
   // Drive and check
   //******************************

   task automatic check_outputs();
      assert (out.valid === exp_valid) else report_mismatch("out.valid", out.valid, exp_valid);
      assert (wr_full === exp_full) else report_mismatch("wr_full", wr_full, exp_full);
      assert (wr_overflow === exp_ovf) else report_mismatch("wr_overflow", wr_overflow, exp_ovf);
      assert (rd_underflow === exp_unf) else report_mismatch("rd_underflow", rd_underflow, exp_unf);
      if (exp_valid) begin
         assert (out.wide === exp_wide) else report_mismatch("out.wide", out.wide, exp_wide);
         assert (out.data === exp_data) else report_mismatch("out.data", out.data, exp_data);
      end
   endtask

   // Starts on a falling edge and returns on the next one
   task automatic run_cycle(input logic we, input rxdp_pkg::rx_word_t d, input logic stop,
                            input logic req, input logic wide);
      wr_en        = we;
      wr_data      = d;
      r_stop_write = stop;
      rd_req       = req;
      rd_wide      = wide;
      model_edge();
      @(posedge wr_clk);
      @(negedge wr_clk);                          // Registered outputs settled
      check_outputs();
   endtask

   task automatic write_word(input logic stop);
      run_cycle(1'b1, rand_bits(40), stop, 1'b0, 1'b0);
   endtask

   task automatic read_req(input logic wide);
      run_cycle(1'b0, '0, r_stop_write, 1'b1, wide);
   endtask

   // One quiet edge so the last pulses are seen low
   task automatic idle_cycle();
      run_cycle(1'b0, '0, r_stop_write, 1'b0, 1'b0);
   endtask

   //******************************
   // Stimulus
   //******************************

   initial begin
      wr_clk       = 1'b0;
      wr_rst_n     = 1'b0;
      wr_en        = 1'b0;
      wr_data      = '0;
      r_stop_write = 1'b1;
      rd_req       = 1'b0;
      rd_wide      = 1'b0;
      lfsr         = 32'hc82c27b6;
      exp_valid    = 1'b0;
      exp_wide     = 1'b0;
      exp_data     = '0;
      exp_full     = 1'b0;
      exp_ovf      = 1'b0;
      exp_unf      = 1'b0;
      repeat (16) @(negedge wr_clk);              // Reset held 16 cycles
      wr_rst_n = 1'b1;
      check_outputs();                            // All pulses low after reset

      // Narrow reads with the first one underflowing on the empty FIFO
      read_req(1'b0);
      for (int k = 0; k < 6; k++) begin
         write_word(1'b1);
      end
      for (int k = 0; k < 3; k++) begin
         read_req(1'b0);
      end
      run_cycle(1'b1, rand_bits(40), 1'b1, 1'b1, 1'b0);  // Write and pop together
      for (int k = 0; k < 4; k++) begin
         read_req(1'b0);
      end
      idle_cycle();

      // Wide reads, then a wide request with one entry left
      for (int k = 0; k < 5; k++) begin
         write_word(1'b1);
      end
      read_req(1'b1);
      read_req(1'b1);
      read_req(1'b1);                             // Only one entry
      read_req(1'b0);                             // That entry still there
      idle_cycle();

      // Fill with stop set so the 17th word is dropped
      for (int k = 0; k < DEPTH + 1; k++) begin
         write_word(1'b1);
      end
      for (int k = 0; k < DEPTH + 1; k++) begin
         read_req(1'b0);
      end
      idle_cycle();

      // Fill with stop clear so the oldest entries are evicted
      for (int k = 0; k < DEPTH + 5; k++) begin
         write_word(1'b0);
      end
      for (int k = 0; k < DEPTH / 2 + 1; k++) begin
         read_req(1'b1);
      end
      idle_cycle();

      // Random mix with write odds swinging between empty and full
      for (int seg = 0; seg < 4; seg++) begin
         wr_thr = (seg % 2 == 0) ? 7 : 2;
         for (int k = 0; k < 500; k++) begin
            run_cycle(rand_bits(3) < wr_thr, rand_bits(40), 1'(rand_bits(1)),
                      1'(rand_bits(1)), 1'(rand_bits(1)));
         end
      end
      idle_cycle();

      $display("TEST PASS");
      $finish;
   end

endmodule
